//--- flist.f
verilog/cw_pkg.sv
verilog/cw_cfg_if.sv
verilog/cw_regfile.sv
verilog/cw_trigger_route.sv
verilog/cw_target_io.sv
verilog/cw_target_power.sv
verilog/cw_ctrl_top.sv
sim/tb_cw_ctrl.sv

//--- Makefile
TOP := tb_cw_ctrl

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module cw_ctrl_top

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_cw_ctrl.sv
`timescale 1ns/1ns

module tb_cw_ctrl;

	localparam int PWM_BITS = 4;
	localparam int SOFT_STEPS = 3;
	localparam int SOFT_WINDOW = (SOFT_STEPS + 1) * (2 ** PWM_BITS) + 6; // align period plus latency

	logic clk;
	logic reset;
	cw_pkg::reg_addr_t reg_address_i;
	cw_pkg::reg_count_t reg_bytecnt_i;
	cw_pkg::reg_byte_t reg_datai_i;
	logic reg_read_i, reg_write_i, reg_addrvalid_i;
	cw_pkg::reg_byte_t reg_datao_o;
	cw_pkg::reg_addr_t reg_hypaddress_i;
	cw_pkg::reg_count_t reg_hyplen_o;
	logic trigger_fpa_i, trigger_fpb_i;
	cw_pkg::io_vec_t trigger_io_i;
	logic trigger_advio_i, trigger_anapattern_i, trigger_decodedio_i;
	logic trigger_ext_o, trigger_o;
	logic trigger_fpa_o, trigger_fpa_oe_o, trigger_fpb_o, trigger_fpb_oe_o;
	logic uart_tx_i, usi_out_i;
	cw_pkg::io_vec_t targetio_i, targetio_o, targetio_oe_o;
	logic uart_rx_o, usi_in_o, enable_avrprog_o;
	logic enable_output_nrst_o, output_nrst_o;
	logic enable_output_pdid_o, output_pdid_o;
	logic enable_output_pdic_o, output_pdic_o;
	logic targetpower_off_o, led_auxi_o, led_auxo_o;

	cw_pkg::reg_byte_t model_extclk, model_trigsrc, model_trigmod; // expected register contents
	cw_pkg::iorouting_t model_iorouting;
	cw_pkg::reg_addr_t known_addrs [4];
	cw_pkg::reg_addr_t unknown_addrs [4];
	integer seed;
	int value_errors;
	int timeout_errors;

	cw_ctrl_top #(.PWM_BITS(PWM_BITS), .SOFT_STEPS(SOFT_STEPS)) u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// a read without a valid address in the cycle before must leave the bus at zero
	idle_read_zero: assert property (@(posedge clk) disable iff (reset)
		!$past(reg_addrvalid_i) |-> reg_datao_o == 8'h00)
	else begin
		value_errors++;
		$display("CHECK FAILED reg_datao_o: expected 0x0, got 0x%0h", $sampled(reg_datao_o));
	end

	task automatic check_val(input string name, input logic [63:0] act, input logic [63:0] exp);
		assert (act === exp) else begin
			value_errors++;
			$display("CHECK FAILED %s: expected 0x%0h, got 0x%0h", name, exp, act);
		end
	endtask

	function automatic cw_pkg::reg_count_t reg_length(input cw_pkg::reg_addr_t a);
		if (a == 6'd55) return 16'd8; // routing word
		if (a == 6'd38 || a == 6'd39 || a == 6'd40) return 16'd1;
		return 16'd0;
	endfunction

	// what a read should return, from the shadow copy
	function automatic cw_pkg::reg_byte_t stored_byte(input cw_pkg::reg_addr_t a,
		input cw_pkg::reg_count_t cnt);
		if (a == 6'd38) return model_extclk;
		if (a == 6'd39) return model_trigsrc;
		if (a == 6'd40) return model_trigmod;
		if (a == 6'd55 && cnt < 16'd8) return model_iorouting[8 * int'(cnt) +: 8];
		return 8'h00;
	endfunction

	function automatic logic combine_sources(input cw_pkg::reg_byte_t ts, input logic [5:0] s);
		logic any_hi;
		logic all_hi;
		any_hi = 1'b0;
		all_hi = 1'b1; // disabled sources do not pull and low
		for (int k = 0; k < 6; k++) begin
			if (ts[k]) begin
				any_hi = any_hi | s[k];
				all_hi = all_hi & s[k];
			end
		end
		case (ts[7:6])
			2'd0: return any_hi;  // or
			2'd1: return all_hi;  // and
			2'd2: return !all_hi; // nand
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic pick_trigger(input cw_pkg::reg_byte_t tm, input logic ext);
		case (tm[2:0])
			3'd0: return ext;
			3'd1: return trigger_advio_i;
			3'd2: return trigger_anapattern_i;
			3'd3: return trigger_decodedio_i;
			default: return 1'b0; // unlisted module
		endcase
	endfunction

	// {enable, value} of one line, ln counts from 0 for line 1
	function automatic logic [1:0] line_expect(input int ln, input cw_pkg::reg_byte_t rt,
		input logic tx, input logic usi);
		if (rt[0]) return {1'b1, tx};
		if (ln == 3) return rt[7] ? {1'b1, rt[6]} : 2'b00; // line 4: tx or gpio only
		if (rt[2]) return {1'b1, usi};
		if (ln == 2 && rt[4]) return {!usi, 1'b0}; // open collector usi
		if (ln == 2 && rt[5]) return {!tx, 1'b0};  // open collector tx
		if (rt[7]) return {1'b1, rt[6]};
		return 2'b00;
	endfunction

	// all bus tasks start and end on a falling edge
	task automatic write_reg(input cw_pkg::reg_addr_t a, input cw_pkg::reg_count_t cnt,
		input cw_pkg::reg_byte_t d);
		reg_address_i = a;
		reg_bytecnt_i = cnt;
		reg_datai_i = d;
		reg_write_i = 1'b1;
		if (a == 6'd38) model_extclk = d;
		else if (a == 6'd39) model_trigsrc = d;
		else if (a == 6'd40) model_trigmod = d;
		else if (a == 6'd55 && cnt < 16'd8) model_iorouting[8 * int'(cnt) +: 8] = d;
		@(negedge clk);
		reg_write_i = 1'b0;
	endtask

	task automatic verify_read(input cw_pkg::reg_addr_t a, input cw_pkg::reg_count_t cnt,
		input cw_pkg::reg_byte_t exp);
		reg_address_i = a;
		reg_bytecnt_i = cnt;
		reg_read_i = 1'b1;
		reg_addrvalid_i = 1'b1;
		@(negedge clk); // data shows one cycle after sampling
		check_val("reg_datao_o", 64'(reg_datao_o), 64'(exp));
		reg_read_i = 1'b0;
		reg_addrvalid_i = 1'b0;
	endtask

	task automatic check_length(input cw_pkg::reg_addr_t a);
		reg_hypaddress_i = a;
		#1;
		check_val("reg_hyplen_o", 64'(reg_hyplen_o), 64'(reg_length(a)));
		@(negedge clk);
	endtask

	task automatic trigger_vector();
		logic ext;
		logic trig;
		trigger_fpa_i = 1'($random(seed));
		trigger_fpb_i = 1'($random(seed));
		trigger_io_i = 4'($random(seed));
		trigger_advio_i = 1'($random(seed));
		trigger_anapattern_i = 1'($random(seed));
		trigger_decodedio_i = 1'($random(seed));
		#1;
		ext = combine_sources(model_trigsrc, {trigger_io_i, trigger_fpb_i, trigger_fpa_i});
		trig = pick_trigger(model_trigmod, ext);
		check_val("trigger_ext_o", 64'(trigger_ext_o), 64'(ext));
		check_val("trigger_o", 64'(trigger_o), 64'(trig));
		check_val("trigger_fpa_o", 64'(trigger_fpa_o), 64'(trig));
		check_val("trigger_fpb_o", 64'(trigger_fpb_o), 64'(trig));
		check_val("trigger_fpa_oe_o", 64'(trigger_fpa_oe_o), 64'(model_trigmod[3]));
		check_val("trigger_fpb_oe_o", 64'(trigger_fpb_oe_o), 64'(model_trigmod[4]));
		check_val("led_auxi_o", 64'(led_auxi_o), 64'(model_trigsrc[0]));
		check_val("led_auxo_o", 64'(led_auxo_o),
			64'(model_extclk[3] | model_extclk[4] | model_trigmod[3]));
		@(negedge clk);
	endtask

	task automatic io_vector();
		cw_pkg::reg_byte_t rt;
		logic [1:0] drv;
		logic [3:0] oe_exp, val_exp, mask;
		logic rx_exp, usi_exp, rx_found, usi_found;
		uart_tx_i = 1'($random(seed));
		usi_out_i = 1'($random(seed));
		targetio_i = 4'($random(seed));
		#1;
		rx_exp = 1'b1; // idle high when no line is routed
		usi_exp = 1'b1;
		rx_found = 1'b0;
		usi_found = 1'b0;
		for (int ln = 0; ln < 4; ln++) begin
			rt = model_iorouting[8 * ln +: 8];
			drv = line_expect(ln, rt, uart_tx_i, usi_out_i);
			mask[ln] = drv[1];
			oe_exp[ln] = drv[1] & ~model_iorouting[41]; // power off floats the lines
			val_exp[ln] = drv[0];
			if (!rx_found && rt[1]) begin
				rx_exp = targetio_i[ln];
				rx_found = 1'b1;
			end
			if (!usi_found && ln < 3 && rt[3]) begin
				usi_exp = targetio_i[ln];
				usi_found = 1'b1;
			end
		end
		check_val("targetio_oe_o", 64'(targetio_oe_o), 64'(oe_exp));
		check_val("targetio_o", 64'(targetio_o & mask), 64'(val_exp & mask)); // driven lines only
		check_val("uart_rx_o", 64'(uart_rx_o), 64'(rx_exp));
		check_val("usi_in_o", 64'(usi_in_o), 64'(usi_exp));
		check_val("enable_avrprog_o", 64'(enable_avrprog_o), 64'(model_iorouting[40]));
		check_val("enable_output_nrst_o", 64'(enable_output_nrst_o), 64'(model_iorouting[48]));
		check_val("output_nrst_o", 64'(output_nrst_o), 64'(model_iorouting[49]));
		check_val("enable_output_pdid_o", 64'(enable_output_pdid_o), 64'(model_iorouting[50]));
		check_val("output_pdid_o", 64'(output_pdid_o), 64'(model_iorouting[51]));
		check_val("enable_output_pdic_o", 64'(enable_output_pdic_o), 64'(model_iorouting[52]));
		check_val("output_pdic_o", 64'(output_pdic_o), 64'(model_iorouting[53]));
		@(negedge clk);
	endtask

	task automatic stay_powered(input int n);
		for (int k = 0; k < n; k++) begin
			check_val("targetpower_off_o", 64'(targetpower_off_o), 64'd0);
			@(negedge clk);
		end
	endtask

	task automatic soft_start_test();
		int cyc;
		logic seen_hi, seen_lo;
		write_reg(6'd55, 16'd5, 8'h02); // power off, fast start clear
		@(negedge clk);
		write_reg(6'd55, 16'd5, 8'h00);
		@(negedge clk); // registered bit now clear
		cyc = 1;
		seen_hi = 1'b0;
		seen_lo = 1'b0;
		while (!(seen_hi && seen_lo) && cyc < SOFT_WINDOW) begin
			if (targetpower_off_o) seen_hi = 1'b1;
			else if (seen_hi) seen_lo = 1'b1; // low again after a high phase
			@(negedge clk);
			cyc++;
		end
		if (!(seen_hi && seen_lo)) begin
			timeout_errors++;
			$display("timeout: targetpower_off_o did not toggle within the soft start window");
		end
		while (cyc < SOFT_WINDOW) begin
			@(negedge clk);
			cyc++;
		end
		stay_powered(64);
	endtask

	initial begin
		seed = 32'hf6c3;
		value_errors = 0;
		timeout_errors = 0;
		reset = 1'b1;
		reg_address_i = '0;
		reg_bytecnt_i = '0;
		reg_datai_i = '0;
		reg_read_i = 1'b0;
		reg_write_i = 1'b0;
		reg_addrvalid_i = 1'b0;
		reg_hypaddress_i = '0;
		trigger_fpa_i = 1'b0;
		trigger_fpb_i = 1'b0;
		trigger_io_i = '0;
		trigger_advio_i = 1'b0;
		trigger_anapattern_i = 1'b0;
		trigger_decodedio_i = 1'b0;
		uart_tx_i = 1'b1;
		usi_out_i = 1'b1;
		targetio_i = '0;
		model_extclk = 8'h03;
		model_trigsrc = 8'h01;
		model_trigmod = 8'h00;
		model_iorouting = 64'h0201; // line 1 tx, line 2 rx
		known_addrs = '{6'd38, 6'd39, 6'd40, 6'd55};
		unknown_addrs = '{6'd0, 6'd37, 6'd41, 6'd63};
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// reset values
		check_val("reg_datao_o", 64'(reg_datao_o), 64'd0);
		check_val("targetpower_off_o", 64'(targetpower_off_o), 64'd0);
		check_val("trigger_fpb_oe_o", 64'(trigger_fpb_oe_o), 64'd0);
		check_val("targetio_oe_o[0]", 64'(targetio_oe_o[0]), 64'd1);
		verify_read(6'd38, 16'd0, 8'h03);
		verify_read(6'd39, 16'd0, 8'h01);
		verify_read(6'd40, 16'd0, 8'h00);
		verify_read(6'd55, 16'd0, 8'h01);
		verify_read(6'd55, 16'd1, 8'h02);
		for (int k = 0; k < 4; k++) check_length(known_addrs[k]);
		for (int k = 0; k < 4; k++) check_length(unknown_addrs[k]);

		// write and read back, then unknown addresses
		for (int r = 0; r < 3; r++) begin
			write_reg(known_addrs[r], 16'd0, 8'($random(seed)));
			verify_read(known_addrs[r], 16'd0, stored_byte(known_addrs[r], 16'd0));
		end
		for (int b = 0; b < 8; b++) begin
			write_reg(6'd55, 16'(b), 8'($random(seed)));
			verify_read(6'd55, 16'(b), stored_byte(6'd55, 16'(b)));
		end
		for (int k = 0; k < 4; k++) begin
			write_reg(unknown_addrs[k], 16'($random(seed) & 7), 8'($random(seed)));
			verify_read(unknown_addrs[k], 16'd0, 8'h00);
		end
		for (int r = 0; r < 3; r++) begin
			verify_read(known_addrs[r], 16'd0, stored_byte(known_addrs[r], 16'd0));
		end
		for (int b = 0; b < 8; b++) begin
			verify_read(6'd55, 16'(b), stored_byte(6'd55, 16'(b)));
		end

		// trigger combination and select
		repeat (12) begin
			write_reg(6'd38, 16'd0, 8'($random(seed)));
			write_reg(6'd39, 16'd0, 8'($random(seed)));
			write_reg(6'd40, 16'd0, 8'($random(seed)));
			repeat (8) trigger_vector();
		end

		// io routing, bytes 0..6 carry everything that is routed
		repeat (12) begin
			for (int b = 0; b < 7; b++) write_reg(6'd55, 16'(b), 8'($random(seed)));
			repeat (8) io_vector();
		end

		// power off with fast start, from power on with line 1 driven
		write_reg(6'd55, 16'd0, 8'h01);
		write_reg(6'd55, 16'd5, 8'h04);
		@(negedge clk);
		check_val("targetio_oe_o[0]", 64'(targetio_oe_o[0]), 64'd1);
		write_reg(6'd55, 16'd5, 8'h06);
		@(negedge clk);
		check_val("targetpower_off_o", 64'(targetpower_off_o), 64'd1);
		check_val("targetio_oe_o", 64'(targetio_oe_o), 64'd0);
		write_reg(6'd55, 16'd5, 8'h04);
		check_val("targetpower_off_o", 64'(targetpower_off_o), 64'd1); // bit not yet registered
		@(negedge clk);
		stay_powered(32);

		soft_start_test();

		$display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- verilog/cw_ctrl_top.sv
`timescale 1ns/1ns

module cw_ctrl_top #(
	parameter int PWM_BITS = 11,
	parameter int SOFT_STEPS = 16383
) (
	input logic clk,
	input logic reset,
	// register bus
	input cw_pkg::reg_addr_t reg_address_i,
	input cw_pkg::reg_count_t reg_bytecnt_i,
	input cw_pkg::reg_byte_t reg_datai_i,
	input logic reg_read_i,
	input logic reg_write_i,
	input logic reg_addrvalid_i,
	output cw_pkg::reg_byte_t reg_datao_o,
	input cw_pkg::reg_addr_t reg_hypaddress_i,
	output cw_pkg::reg_count_t reg_hyplen_o,
	// triggers
	input logic trigger_fpa_i,
	input logic trigger_fpb_i,
	input cw_pkg::io_vec_t trigger_io_i,
	input logic trigger_advio_i,
	input logic trigger_anapattern_i,
	input logic trigger_decodedio_i,
	output logic trigger_ext_o,
	output logic trigger_o,
	output logic trigger_fpa_o,
	output logic trigger_fpa_oe_o,
	output logic trigger_fpb_o,
	output logic trigger_fpb_oe_o,
	// target io
	input logic uart_tx_i,
	input logic usi_out_i,
	input cw_pkg::io_vec_t targetio_i,
	output cw_pkg::io_vec_t targetio_o,
	output cw_pkg::io_vec_t targetio_oe_o,
	output logic uart_rx_o,
	output logic usi_in_o,
	output logic enable_avrprog_o,
	output logic enable_output_nrst_o,
	output logic output_nrst_o,
	output logic enable_output_pdid_o,
	output logic output_pdid_o,
	output logic enable_output_pdic_o,
	output logic output_pdic_o,
	// power and leds
	output logic targetpower_off_o,
	output logic led_auxi_o,
	output logic led_auxo_o
);

	logic io_highz; // from power control to io routing

	cw_cfg_if u_cfg ();

	cw_regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.reg_address_i(reg_address_i),
		.reg_bytecnt_i(reg_bytecnt_i),
		.reg_datai_i(reg_datai_i),
		.reg_read_i(reg_read_i),
		.reg_write_i(reg_write_i),
		.reg_addrvalid_i(reg_addrvalid_i),
		.reg_datao_o(reg_datao_o),
		.reg_hypaddress_i(reg_hypaddress_i),
		.reg_hyplen_o(reg_hyplen_o),
		.cfg(u_cfg.regs)
	);

	cw_trigger_route u_trigger_route (
		.cfg(u_cfg.use_cfg),
		.trigger_fpa_i(trigger_fpa_i),
		.trigger_fpb_i(trigger_fpb_i),
		.trigger_io_i(trigger_io_i),
		.trigger_advio_i(trigger_advio_i),
		.trigger_anapattern_i(trigger_anapattern_i),
		.trigger_decodedio_i(trigger_decodedio_i),
		.trigger_ext_o(trigger_ext_o),
		.trigger_o(trigger_o),
		.trigger_fpa_o(trigger_fpa_o),
		.trigger_fpa_oe_o(trigger_fpa_oe_o),
		.trigger_fpb_o(trigger_fpb_o),
		.trigger_fpb_oe_o(trigger_fpb_oe_o)
	);

	cw_target_io u_target_io (
		.cfg(u_cfg.use_cfg),
		.io_highz_i(io_highz),
		.uart_tx_i(uart_tx_i),
		.usi_out_i(usi_out_i),
		.targetio_i(targetio_i),
		.targetio_o(targetio_o),
		.targetio_oe_o(targetio_oe_o),
		.uart_rx_o(uart_rx_o),
		.usi_in_o(usi_in_o),
		.enable_avrprog_o(enable_avrprog_o),
		.enable_output_nrst_o(enable_output_nrst_o),
		.output_nrst_o(output_nrst_o),
		.enable_output_pdid_o(enable_output_pdid_o),
		.output_pdid_o(output_pdid_o),
		.enable_output_pdic_o(enable_output_pdic_o),
		.output_pdic_o(output_pdic_o)
	);

	cw_target_power #(
		.PWM_BITS(PWM_BITS),
		.SOFT_STEPS(SOFT_STEPS)
	) u_target_power (
		.clk(clk),
		.reset(reset),
		.cfg(u_cfg.use_cfg),
		.targetpower_off_o(targetpower_off_o),
		.io_highz_o(io_highz)
	);

	assign led_auxi_o = u_cfg.trigsrc[0]; // front panel a used as trigger input
	// front panel a used as output, by the old clock modes or the trigger drive
	assign led_auxo_o = u_cfg.extclk[4] | u_cfg.extclk[3] |
		u_cfg.trigmod[cw_pkg::TRIGMOD_FPA];

endmodule

//--- verilog/cw_target_power.sv
`timescale 1ns/1ns

module cw_target_power #(
	parameter int PWM_BITS = 11,   // pwm period is 2^PWM_BITS cycles, at least 4
	parameter int SOFT_STEPS = 16383 // number of pwm periods in a soft start
) (
	input logic clk,
	input logic reset,
	cw_cfg_if.use_cfg cfg,
	output logic targetpower_off_o, // high switches target power off
	output logic io_highz_o        // float target io while unpowered
);

	localparam int STEP_BITS = $clog2(SOFT_STEPS + 1);
	localparam logic [STEP_BITS-1:0] STEP_LAST = STEP_BITS'(SOFT_STEPS - 1);

	cw_pkg::power_state_t state;
	logic pwr_off_q;              // registered power-off bit
	logic [PWM_BITS-1:0] pwm_cnt; // free running pwm phase
	logic [STEP_BITS-1:0] step_cnt; // soft start periods done
	logic pwm_run;                // soft start aligned to a period start
	logic pwm_wrap;               // last cycle of a pwm period
	logic pwm_high;               // off phase of the pwm

	assign pwm_wrap = &pwm_cnt;
	assign pwm_high = pwm_cnt[PWM_BITS-1 -: 4] < cw_pkg::SOFT_DUTY; // first 11/16

	always_ff @(posedge clk) begin
		if (reset) begin
			pwm_cnt <= '0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pwr_off_q <= 1'b0;
			state <= cw_pkg::PWR_ON;
			step_cnt <= '0;
			pwm_run <= 1'b0;
		end else begin
			pwr_off_q <= cfg.iorouting[cw_pkg::RT_PWR_OFF];
			case (state)
				cw_pkg::PWR_ON: begin
					if (pwr_off_q) state <= cw_pkg::PWR_OFF;
				end
				cw_pkg::PWR_OFF: begin
					step_cnt <= '0;
					pwm_run <= 1'b0;
					if (!pwr_off_q) begin // registered off to on edge
						state <= cfg.iorouting[cw_pkg::RT_FAST_START] ?
							cw_pkg::PWR_ON : cw_pkg::PWR_SOFT;
					end
				end
				cw_pkg::PWR_SOFT: begin
					if (pwr_off_q) begin
						state <= cw_pkg::PWR_OFF; // turned off mid soft start
					end else if (pwm_wrap) begin
						if (!pwm_run) begin
							pwm_run <= 1'b1; // wait for a full period
						end else if (step_cnt == STEP_LAST) begin
							state <= cw_pkg::PWR_ON;
						end else begin
							step_cnt <= step_cnt + 1'b1;
						end
					end
				end
				default: state <= cw_pkg::PWR_ON;
			endcase
		end
	end

	// pwm only while soft starting, otherwise follow the register bit
	assign targetpower_off_o = pwr_off_q |
		((state == cw_pkg::PWR_SOFT) & pwm_run & pwm_high);
	assign io_highz_o = pwr_off_q;

endmodule

//--- verilog/cw_target_io.sv
`timescale 1ns/1ns

module cw_target_io (
	cw_cfg_if.use_cfg cfg,
	input logic io_highz_i,               // target unpowered, float all lines
	input logic uart_tx_i,
	input logic usi_out_i,
	input cw_pkg::io_vec_t targetio_i,     // pad input values
	output cw_pkg::io_vec_t targetio_o,    // pad output values
	output cw_pkg::io_vec_t targetio_oe_o, // pad output enables
	output logic uart_rx_o,
	output logic usi_in_o,
	output logic enable_avrprog_o,
	output logic enable_output_nrst_o,
	output logic output_nrst_o,
	output logic enable_output_pdid_o,
	output logic output_pdid_o,
	output logic enable_output_pdic_o,
	output logic output_pdic_o
);

	localparam int LINES = $bits(cw_pkg::io_vec_t);

	// one line's drive as {oe, value}, first match wins
	function automatic logic [1:0] line_drive(
		input cw_pkg::reg_byte_t rt, // routing byte of the line
		input logic usi_ok,          // line supports usi out
		input logic oc_ok,           // line supports the open collector modes
		input logic tx,
		input logic usi
	);
		logic [1:0] drv;
		drv = 2'b00; // not driven
		if (rt[cw_pkg::RT_TX_OUT]) begin
			drv = {1'b1, tx};
		end else if (usi_ok && rt[cw_pkg::RT_USI_OUT]) begin
			drv = {1'b1, usi};
		end else if (oc_ok && rt[cw_pkg::RT_USI_OC]) begin
			drv = {~usi, 1'b0}; // pull low only, high is released
		end else if (oc_ok && rt[cw_pkg::RT_TX_OC]) begin
			drv = {~tx, 1'b0};
		end else if (rt[cw_pkg::RT_GPIO_EN]) begin
			drv = {1'b1, rt[cw_pkg::RT_GPIO_VAL]};
		end
		return drv;
	endfunction

	for (genvar i = 0; i < LINES; i++) begin : g_line
		logic [1:0] drv;
		// line 4 has tx and gpio only, open collector on line 3 only
		assign drv = line_drive(cfg.iorouting[8*i +: 8], i < LINES - 1, i == 2,
			uart_tx_i, usi_out_i);
		assign targetio_o[i] = drv[0];
		assign targetio_oe_o[i] = drv[1] & ~io_highz_i; // power off floats everything
	end

	// inputs take the lowest numbered line with its in-bit set
	always_comb begin
		uart_rx_o = 1'b1; // uart idles high
		usi_in_o = 1'b1;
		for (int i = LINES - 1; i >= 0; i--) begin
			if (cfg.iorouting[8*i + cw_pkg::RT_RX_IN]) begin
				uart_rx_o = targetio_i[i];
			end
			if ((i < LINES - 1) && cfg.iorouting[8*i + cw_pkg::RT_USI_IN]) begin
				usi_in_o = targetio_i[i]; // no usi in on line 4
			end
		end
	end

	// direct gpio from the extra bytes
	assign enable_avrprog_o = cfg.iorouting[cw_pkg::RT_AVRPROG];
	assign enable_output_nrst_o = cfg.iorouting[cw_pkg::RT_NRST_EN];
	assign output_nrst_o = cfg.iorouting[cw_pkg::RT_NRST_VAL];
	assign enable_output_pdid_o = cfg.iorouting[cw_pkg::RT_PDID_EN];
	assign output_pdid_o = cfg.iorouting[cw_pkg::RT_PDID_VAL];
	assign enable_output_pdic_o = cfg.iorouting[cw_pkg::RT_PDIC_EN];
	assign output_pdic_o = cfg.iorouting[cw_pkg::RT_PDIC_VAL];

endmodule

//--- verilog/cw_trigger_route.sv
`timescale 1ns/1ns

module cw_trigger_route (
	cw_cfg_if.use_cfg cfg,
	input logic trigger_fpa_i,          // front panel a in
	input logic trigger_fpb_i,          // front panel b in
	input cw_pkg::io_vec_t trigger_io_i, // target io lines 1..4
	input logic trigger_advio_i,        // advanced io pattern trigger
	input logic trigger_anapattern_i,   // analog pattern trigger
	input logic trigger_decodedio_i,    // decoded io trigger
	output logic trigger_ext_o,         // combined external trigger
	output logic trigger_o,             // final trigger to capture
	output logic trigger_fpa_o,
	output logic trigger_fpa_oe_o,
	output logic trigger_fpb_o,
	output logic trigger_fpb_oe_o
);

	logic [5:0] src;    // fpa, fpb, io1..io4 in enable bit order
	logic [5:0] src_en; // enable bits from trigsrc
	logic trig_or;
	logic trig_and;
	logic trig_ext;
	logic trig;

	assign src = {trigger_io_i, trigger_fpb_i, trigger_fpa_i};
	assign src_en = cfg.trigsrc[5:0];

	assign trig_or = |(src & src_en);   // nothing enabled gives 0
	assign trig_and = &(src | ~src_en); // disabled sources count as 1

	// combine mode sits in trigsrc[7:6]
	always_comb begin
		case (cw_pkg::trig_comb_t'(cfg.trigsrc[7:6]))
			cw_pkg::OR: trig_ext = trig_or;
			cw_pkg::AND: trig_ext = trig_and;
			cw_pkg::NAND: trig_ext = ~trig_and;
			cw_pkg::NONE: trig_ext = 1'b0;
			default: trig_ext = 1'b0;
		endcase
	end

	// trigger module select
	always_comb begin
		case (cw_pkg::trig_mod_t'(cfg.trigmod[2:0]))
			cw_pkg::EXT: trig = trig_ext;
			cw_pkg::ADVIO: trig = trigger_advio_i;
			cw_pkg::ANAPATTERN: trig = trigger_anapattern_i;
			cw_pkg::DECODEDIO: trig = trigger_decodedio_i;
			default: trig = 1'b0; // modes 4..7 unused
		endcase
	end

	assign trigger_ext_o = trig_ext;
	assign trigger_o = trig;

	// front panel drive, value always present, enable from trigmod
	assign trigger_fpa_o = trig;
	assign trigger_fpa_oe_o = cfg.trigmod[cw_pkg::TRIGMOD_FPA];
	assign trigger_fpb_o = trig;
	assign trigger_fpb_oe_o = cfg.trigmod[cw_pkg::TRIGMOD_FPB];

endmodule

//--- verilog/cw_regfile.sv
`timescale 1ns/1ns

module cw_regfile (
	input logic clk,
	input logic reset,
	input cw_pkg::reg_addr_t reg_address_i,   // address of the access
	input cw_pkg::reg_count_t reg_bytecnt_i,  // byte within a multi-byte register
	input cw_pkg::reg_byte_t reg_datai_i,     // write data
	input logic reg_read_i,                   // read strobe
	input logic reg_write_i,                  // write strobe, one cycle
	input logic reg_addrvalid_i,              // address qualifies a read
	output cw_pkg::reg_byte_t reg_datao_o,    // read data, zero when not ours
	input cw_pkg::reg_addr_t reg_hypaddress_i, // length lookup address
	output cw_pkg::reg_count_t reg_hyplen_o,  // length of that register
	cw_cfg_if.regs cfg
);

	cw_pkg::reg_byte_t extclk_q;
	cw_pkg::reg_byte_t trigsrc_q;
	cw_pkg::reg_byte_t trigmod_q;
	cw_pkg::iorouting_t iorouting_q;

	cw_pkg::reg_byte_t rd_byte;  // byte picked for the current read
	cw_pkg::reg_byte_t rd_byte_q; // registered read data
	logic rd_valid_q;            // last sampled address hit one of ours
	logic addr_hit;              // address is one of the four registers
	logic byte_ok;               // byte count inside the routing word
	logic [5:0] byte_sel;        // bit offset of the addressed routing byte

	assign byte_ok = reg_bytecnt_i < cw_pkg::IOROUTE_BYTES;
	assign byte_sel = {reg_bytecnt_i[2:0], 3'b000};

	assign addr_hit = (reg_address_i == cw_pkg::ADDR_EXTCLK) ||
		(reg_address_i == cw_pkg::ADDR_TRIGSRC) ||
		(reg_address_i == cw_pkg::ADDR_TRIGMOD) ||
		(reg_address_i == cw_pkg::ADDR_IOROUTE);

	// register storage, byte writes into the routing word
	always_ff @(posedge clk) begin
		if (reset) begin
			extclk_q <= cw_pkg::RST_EXTCLK;
			trigsrc_q <= cw_pkg::RST_TRIGSRC;
			trigmod_q <= cw_pkg::RST_TRIGMOD;
			iorouting_q <= cw_pkg::RST_IOROUTE;
		end else if (reg_write_i) begin
			case (reg_address_i)
				cw_pkg::ADDR_EXTCLK: extclk_q <= reg_datai_i;
				cw_pkg::ADDR_TRIGSRC: trigsrc_q <= reg_datai_i;
				cw_pkg::ADDR_TRIGMOD: trigmod_q <= reg_datai_i;
				cw_pkg::ADDR_IOROUTE: begin
					if (byte_ok) begin
						iorouting_q[byte_sel +: 8] <= reg_datai_i; // bytecnt picks the byte
					end
				end
				default: ; // unknown address, write dropped
			endcase
		end
	end

	// read mux
	always_comb begin
		case (reg_address_i)
			cw_pkg::ADDR_EXTCLK: rd_byte = extclk_q;
			cw_pkg::ADDR_TRIGSRC: rd_byte = trigsrc_q;
			cw_pkg::ADDR_TRIGMOD: rd_byte = trigmod_q;
			cw_pkg::ADDR_IOROUTE: rd_byte = byte_ok ? iorouting_q[byte_sel +: 8] : 8'h00;
			default: rd_byte = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reg_read_i) begin
			rd_byte_q <= rd_byte; // held between reads
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= reg_addrvalid_i & addr_hit; // other slaves share the read bus
		end
	end

	assign reg_datao_o = rd_valid_q ? rd_byte_q : 8'h00;

	// length lookup, purely combinational
	always_comb begin
		case (reg_hypaddress_i)
			cw_pkg::ADDR_EXTCLK: reg_hyplen_o = 16'd1;
			cw_pkg::ADDR_TRIGSRC: reg_hyplen_o = 16'd1;
			cw_pkg::ADDR_TRIGMOD: reg_hyplen_o = 16'd1;
			cw_pkg::ADDR_IOROUTE: reg_hyplen_o = cw_pkg::IOROUTE_BYTES;
			default: reg_hyplen_o = 16'd0;
		endcase
	end

	assign cfg.extclk = extclk_q;
	assign cfg.trigsrc = trigsrc_q;
	assign cfg.trigmod = trigmod_q;
	assign cfg.iorouting = iorouting_q;

endmodule

//--- verilog/cw_cfg_if.sv
`timescale 1ns/1ns

interface cw_cfg_if;

	cw_pkg::reg_byte_t extclk;     // external clock byte, only feeds the aux led now
	cw_pkg::reg_byte_t trigsrc;    // [7:6] combine mode, [5:0] source enables
	cw_pkg::reg_byte_t trigmod;    // [4:3] front panel drive, [2:0] module select
	cw_pkg::iorouting_t iorouting; // per line routing bytes plus extra bytes

	// register file side
	modport regs (
		output extclk, trigsrc, trigmod, iorouting
	);

	// function modules only look at the registers
	modport use_cfg (
		input extclk, trigsrc, trigmod, iorouting
	);

endinterface

//--- verilog/cw_pkg.sv
package cw_pkg;

	typedef logic [5:0] reg_addr_t;   // register bus address
	typedef logic [7:0] reg_byte_t;   // one register data byte
	typedef logic [15:0] reg_count_t; // byte count and register length
	typedef logic [3:0] io_vec_t;     // one bit per target io line
	typedef logic [63:0] iorouting_t; // eight routing bytes, line 1 in the low byte

	localparam reg_addr_t ADDR_EXTCLK = 6'd38;  // external clock byte
	localparam reg_addr_t ADDR_TRIGSRC = 6'd39; // trigger source byte
	localparam reg_addr_t ADDR_TRIGMOD = 6'd40; // trigger module byte
	localparam reg_addr_t ADDR_IOROUTE = 6'd55; // target io routing word

	localparam reg_count_t IOROUTE_BYTES = 16'd8; // length of the routing register

	localparam reg_byte_t RST_EXTCLK = 8'h03;
	localparam reg_byte_t RST_TRIGSRC = 8'h01;      // front panel a enabled
	localparam reg_byte_t RST_TRIGMOD = 8'h00;      // edge trigger, no front panel drive
	localparam iorouting_t RST_IOROUTE = 64'h0201; // line 1 uart tx, line 2 uart rx

	// field positions inside one line's routing byte
	localparam int RT_TX_OUT = 0;   // uart tx out
	localparam int RT_RX_IN = 1;    // uart rx in
	localparam int RT_USI_OUT = 2;  // usi out
	localparam int RT_USI_IN = 3;   // usi in
	localparam int RT_USI_OC = 4;   // usi out, open collector (line 3 only)
	localparam int RT_TX_OC = 5;    // tx out, open collector (line 3 only)
	localparam int RT_GPIO_VAL = 6; // gpio value
	localparam int RT_GPIO_EN = 7;  // gpio drive enable

	// extra bytes inside the routing word
	localparam int RT_AVRPROG = 40;    // avr programming enable
	localparam int RT_PWR_OFF = 41;    // target power off
	localparam int RT_FAST_START = 42; // skip the soft start
	localparam int RT_NRST_EN = 48;
	localparam int RT_NRST_VAL = 49;
	localparam int RT_PDID_EN = 50;
	localparam int RT_PDID_VAL = 51;
	localparam int RT_PDIC_EN = 52;
	localparam int RT_PDIC_VAL = 53;

	localparam int TRIGMOD_FPA = 3; // drive trigger onto front panel a
	localparam int TRIGMOD_FPB = 4; // drive trigger onto front panel b

	localparam logic [3:0] SOFT_DUTY = 4'd11; // soft start high time in sixteenths

	typedef enum logic [1:0] {OR = 2'd0, AND = 2'd1, NAND = 2'd2, NONE = 2'd3} trig_comb_t;
	typedef enum logic [2:0] {EXT = 3'd0, ADVIO = 3'd1, ANAPATTERN = 3'd2, DECODEDIO = 3'd3} trig_mod_t;
	typedef enum logic [1:0] {PWR_OFF = 2'd0, PWR_SOFT = 2'd1, PWR_ON = 2'd2} power_state_t;

endpackage
